/* verilog/mm_api_pkg.sv */
/*
 * Shared definitions for the command-streaming bus master.
 * Holds the bus and API widths, the method codes, the event bit
 * positions and the command and response records. Modules import it.
 */
`default_nettype none

package mm_api_pkg;

   // bus geometry
   localparam int addr_w      = 32;
   localparam int symbol_w    = 8;
   localparam int num_symbols = 4;
   localparam int data_w      = symbol_w * num_symbols;

   // api stream widths
   localparam int method_w      = 8;
   localparam int call_data_w   = 64;
   localparam int return_data_w = 64;
   localparam int event_w       = 8;

   // method codes of the client API
   typedef enum logic [method_w-1:0] {
      init                    = 8'd0,
      all_trans_complete      = 8'd3,
      get_cmd_pend_queue_size = 8'd5,
      get_resp_queue_size     = 8'd6,
      push_cmd                = 8'd7,
      pop_resp                = 8'd8,
      set_cmd_data            = 8'd9,
      set_cmd_address         = 8'd10,
      set_cmd_byte_enable     = 8'd11,
      set_cmd_request         = 8'd14,
      get_resp_request        = 8'd16,
      get_resp_data           = 8'd17,
      get_resp_address        = 8'd18,
      get_resp_byte_enable    = 8'd19
   } method_t;

   // bit positions in api_event_data
   localparam int ev_response_complete  = 1;
   localparam int ev_command_issued     = 2;
   localparam int ev_all_trans_complete = 3;

   typedef struct packed {
      logic                   write;
      logic [addr_w-1:0]      addr;
      logic [data_w-1:0]      data;
      logic [num_symbols-1:0] be;
   } mm_cmd_t;

   // data holds write data for a write and read data for a read
   typedef struct packed {
      logic                   write;
      logic [addr_w-1:0]      addr;
      logic [data_w-1:0]      data;
      logic [num_symbols-1:0] be;
   } mm_resp_t;

endpackage

`default_nettype wire

/* verilog/mm_api_fifo.sv */
/*
 * Synchronous queue with valid/ready on both sides and an occupancy count.
 * The payload type and the depth are set by the instantiating module.
 * The head entry is shown on out_data without a register stage.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_api_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 4
) (
   input  logic     api_clk,
   input  logic     api_reset,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data,
   output logic [7:0] count
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

   payload_t           mem [depth];
   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;
   logic               push;
   logic               pop;

   assign in_ready  = (count < depth);
   assign out_valid = (count != 8'd0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge api_clk) begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge api_clk or posedge api_reset) begin
      if (api_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= 8'd0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         // simultaneous push and pop leaves the count alone
         if (push && !pop)
            count <= count + 8'd1;
         else if (pop && !push)
            count <= count - 8'd1;
      end
   end

   a_count_bound : assert property (
      @(posedge api_clk) disable iff (api_reset) count <= depth
   );

endmodule

`default_nettype wire

/* verilog/mm_api_decoder.sv */
/*
 * Call decoder for the bus master API.
 * Stages command fields from setter calls, pushes and pops the queues
 * in the call cycle, and registers the return one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_api_decoder
   import mm_api_pkg::*;
(
   input  logic                     api_clk,
   input  logic                     api_reset,
   input  logic                     api_call_valid,
   input  method_t                  api_call_method,
   input  logic [call_data_w-1:0]   api_call_data,
   output logic                     api_return_valid,
   output logic [method_w-1:0]      api_return_method,
   output logic [return_data_w-1:0] api_return_data,
   output logic                     cmd_in_valid,
   output mm_cmd_t                  cmd_in,
   input  logic                     cmd_in_ready,
   input  logic [7:0]               cmd_count,
   input  logic                     resp_out_valid,
   input  mm_resp_t                 resp_out,
   input  logic [7:0]               resp_count,
   output logic                     resp_out_ready,
   input  logic                     engine_idle,
   output logic                     all_complete
);

   mm_cmd_t                  staged;
   logic                     req_ok;
   logic [return_data_w-1:0] ret_value;

   assign cmd_in         = staged;
   assign cmd_in_valid   = api_call_valid && (api_call_method == push_cmd);
   assign resp_out_ready = api_call_valid && (api_call_method == pop_resp);
   assign all_complete   = (cmd_count == 8'd0) && engine_idle;

   // only read (00) and write (01) are legal request codes
   assign req_ok = (api_call_data[1] == 1'b0);

   // staged command register
   always_ff @(posedge api_clk or posedge api_reset) begin
      if (api_reset) begin
         staged.write <= 1'b0;
         staged.addr  <= '0;
         staged.data  <= '0;
         staged.be    <= '1;
      end else if (api_call_valid) begin
         case (api_call_method)
            init: begin
               staged.write <= 1'b0;
               staged.addr  <= '0;
               staged.data  <= '0;
               staged.be    <= '1;
            end
            set_cmd_data:
               staged.data <= api_call_data[data_w-1:0];
            set_cmd_address:
               staged.addr <= api_call_data[addr_w-1:0];
            set_cmd_byte_enable:
               staged.be <= api_call_data[num_symbols-1:0];
            set_cmd_request:
               if (req_ok)
                  staged.write <= api_call_data[0];
            default: ;
         endcase
      end
   end

   // return value from the state seen in the call cycle
   always_comb begin
      ret_value = '0;
      case (api_call_method)
         init, set_cmd_data, set_cmd_address, set_cmd_byte_enable:
            ret_value = return_data_w'(1);
         set_cmd_request:
            ret_value = return_data_w'(req_ok);
         push_cmd:
            ret_value = return_data_w'(cmd_in_ready);
         pop_resp:
            ret_value = return_data_w'(resp_out_valid);
         all_trans_complete:
            ret_value = return_data_w'(all_complete);
         get_cmd_pend_queue_size:
            ret_value = return_data_w'(cmd_count);
         get_resp_queue_size:
            ret_value = return_data_w'(resp_count);
         get_resp_request:
            if (resp_out_valid)
               ret_value = return_data_w'(resp_out.write);
         get_resp_data:
            if (resp_out_valid)
               ret_value = return_data_w'(resp_out.data);
         get_resp_address:
            if (resp_out_valid)
               ret_value = return_data_w'(resp_out.addr);
         get_resp_byte_enable:
            if (resp_out_valid)
               ret_value = return_data_w'(resp_out.be);
         default:
            ret_value = '0;
      endcase
   end

   always_ff @(posedge api_clk or posedge api_reset) begin
      if (api_reset) begin
         api_return_valid  <= 1'b0;
         api_return_method <= '0;
         api_return_data   <= '0;
      end else begin
         api_return_valid <= api_call_valid;
         if (api_call_valid) begin
            api_return_method <= api_call_method;
            api_return_data   <= ret_value;
         end else begin
            api_return_method <= '0;
            api_return_data   <= '0;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/mm_bus_engine.sv */
/*
 * Bus engine: takes one command from the command queue, runs it as a
 * single-word read or write, and pushes the finished transaction into
 * the response queue. Signals issue and completion to the event logic.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_bus_engine
   import mm_api_pkg::*;
(
   input  logic                   api_clk,
   input  logic                   api_reset,
   input  logic                   cmd_out_valid,
   input  mm_cmd_t                cmd_out,
   output logic                   cmd_out_ready,
   output logic                   resp_in_valid,
   output mm_resp_t               resp_in,
   input  logic                   resp_in_ready,
   input  logic                   avm_waitrequest,
   input  logic [data_w-1:0]      avm_readdata,
   input  logic                   avm_readdatavalid,
   output logic                   avm_read,
   output logic                   avm_write,
   output logic [addr_w-1:0]      avm_address,
   output logic [num_symbols-1:0] avm_byteenable,
   output logic [data_w-1:0]      avm_writedata,
   output logic                   engine_idle,
   output logic                   issued,
   output logic                   completed
);

   typedef enum logic [1:0] {
      st_idle,
      st_issue,
      st_rd_wait
   } state_t;

   state_t  state;
   mm_cmd_t cur;

   // a free slot in the response queue stays free until this engine fills it
   assign cmd_out_ready = (state == st_idle) && resp_in_ready;
   assign engine_idle   = (state == st_idle);

   assign avm_read       = (state == st_issue) && !cur.write;
   assign avm_write      = (state == st_issue) && cur.write;
   assign avm_address    = cur.addr;
   assign avm_byteenable = cur.be;
   assign avm_writedata  = cur.data;

   assign issued = (state == st_issue) && !avm_waitrequest;

   // writes finish on the issue edge, reads on read-data-valid
   assign resp_in_valid = (issued && cur.write) ||
                          ((state == st_rd_wait) && avm_readdatavalid);
   assign completed     = resp_in_valid && resp_in_ready;

   always_comb begin
      resp_in.write = cur.write;
      resp_in.addr  = cur.addr;
      resp_in.be    = cur.be;
      resp_in.data  = (state == st_rd_wait) ? avm_readdata : cur.data;
   end

   always_ff @(posedge api_clk) begin
      if (cmd_out_valid && cmd_out_ready)
         cur <= cmd_out;
   end

   always_ff @(posedge api_clk or posedge api_reset) begin
      if (api_reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:
               if (cmd_out_valid && cmd_out_ready)
                  state <= st_issue;
            st_issue:
               if (!avm_waitrequest)
                  state <= cur.write ? st_idle : st_rd_wait;
            st_rd_wait:
               if (avm_readdatavalid)
                  state <= st_idle;
            default:
               state <= st_idle;
         endcase
      end
   end

   a_one_strobe : assert property (
      @(posedge api_clk) disable iff (api_reset) !(avm_read && avm_write)
   );

   a_addr_hold : assert property (
      @(posedge api_clk) disable iff (api_reset)
      (avm_read || avm_write) && avm_waitrequest |=> $stable(avm_address)
   );

   a_rdv_in_wait : assert property (
      @(posedge api_clk) disable iff (api_reset)
      avm_readdatavalid |-> (state == st_rd_wait)
   );

endmodule

`default_nettype wire

/* verilog/mm_event_gen.sv */
/*
 * Event stream generator. Collects the strobes of one cycle into the
 * event vector and presents it, with its valid, on the next cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_event_gen
   import mm_api_pkg::*;
(
   input  logic               api_clk,
   input  logic               api_reset,
   input  logic               issued,
   input  logic               completed,
   input  logic               all_complete,
   output logic               api_event_valid,
   output logic [event_w-1:0] api_event_data
);

   logic               all_complete_q;
   logic [event_w-1:0] next_data;

   always_comb begin
      next_data                        = '0;
      next_data[ev_response_complete]  = completed;
      next_data[ev_command_issued]     = issued;
      next_data[ev_all_trans_complete] = all_complete && !all_complete_q;
   end

   // all_complete_q starts high since the master is idle out of reset
   always_ff @(posedge api_clk or posedge api_reset) begin
      if (api_reset) begin
         all_complete_q  <= 1'b1;
         api_event_valid <= 1'b0;
         api_event_data  <= '0;
      end else begin
         all_complete_q  <= all_complete;
         api_event_valid <= |next_data;
         api_event_data  <= next_data;
      end
   end

endmodule

`default_nettype wire

/* verilog/mm_api_master_top.sv */
/*
 * Top level of the command-streaming bus master.
 * Connects the call decoder, the command and response queues, the bus
 * engine and the event generator. Queue depths are set here.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_api_master_top
   import mm_api_pkg::*;
#(
   parameter int cmd_depth  = 4,
   parameter int resp_depth = 4
) (
   input  logic                     api_clk,
   input  logic                     api_reset,
   input  logic                     api_call_valid,
   input  logic [method_w-1:0]      api_call_method,
   input  logic [call_data_w-1:0]   api_call_data,
   output logic                     api_return_valid,
   output logic [method_w-1:0]      api_return_method,
   output logic [return_data_w-1:0] api_return_data,
   output logic                     api_event_valid,
   output logic [event_w-1:0]       api_event_data,
   output logic                     avm_read,
   output logic                     avm_write,
   output logic [addr_w-1:0]        avm_address,
   output logic [num_symbols-1:0]   avm_byteenable,
   output logic [data_w-1:0]        avm_writedata,
   input  logic                     avm_waitrequest,
   input  logic [data_w-1:0]        avm_readdata,
   input  logic                     avm_readdatavalid
);

   logic       cmd_in_valid, cmd_in_ready, cmd_out_valid, cmd_out_ready;
   logic       resp_in_valid, resp_in_ready, resp_out_valid, resp_out_ready;
   mm_cmd_t    cmd_in, cmd_out;
   mm_resp_t   resp_in, resp_out;
   logic [7:0] cmd_count, resp_count;
   logic       engine_idle, issued, completed, all_complete;

   // undefined codes pass through the cast and hit the decoder default
   mm_api_decoder u_decoder (
      .api_clk, .api_reset, .api_call_valid,
      .api_call_method (method_t'(api_call_method)),
      .api_call_data, .api_return_valid, .api_return_method, .api_return_data,
      .cmd_in_valid, .cmd_in, .cmd_in_ready, .cmd_count,
      .resp_out_valid, .resp_out, .resp_count, .resp_out_ready,
      .engine_idle, .all_complete
   );

   mm_api_fifo #(.payload_t(mm_cmd_t), .depth(cmd_depth)) u_cmd_fifo (
      .api_clk, .api_reset,
      .in_valid (cmd_in_valid), .in_ready (cmd_in_ready), .in_data (cmd_in),
      .out_valid (cmd_out_valid), .out_ready (cmd_out_ready), .out_data (cmd_out),
      .count (cmd_count)
   );

   mm_api_fifo #(.payload_t(mm_resp_t), .depth(resp_depth)) u_resp_fifo (
      .api_clk, .api_reset,
      .in_valid (resp_in_valid), .in_ready (resp_in_ready), .in_data (resp_in),
      .out_valid (resp_out_valid), .out_ready (resp_out_ready), .out_data (resp_out),
      .count (resp_count)
   );

   mm_bus_engine u_engine (
      .api_clk, .api_reset,
      .cmd_out_valid, .cmd_out, .cmd_out_ready,
      .resp_in_valid, .resp_in, .resp_in_ready,
      .avm_waitrequest, .avm_readdata, .avm_readdatavalid,
      .avm_read, .avm_write, .avm_address, .avm_byteenable, .avm_writedata,
      .engine_idle, .issued, .completed
   );

   mm_event_gen u_event_gen (
      .api_clk, .api_reset,
      .issued, .completed, .all_complete,
      .api_event_valid, .api_event_data
   );

endmodule

`default_nettype wire

/* tb/mm_slave_model.sv */
/*
 * Memory slave for the bus master testbench. Answers single-word reads
 * and byte-enabled writes with random wait-request and read latency.
 * Unwritten words read as their address XOR 0xA5A5A5A5.
 */
`timescale 1ns/1ps
`default_nettype none

module mm_slave_model
   import mm_api_pkg::*;
(
   input  logic                   api_clk,
   input  logic                   api_reset,
   input  logic                   avm_read,
   input  logic                   avm_write,
   input  logic [addr_w-1:0]      avm_address,
   input  logic [num_symbols-1:0] avm_byteenable,
   input  logic [data_w-1:0]      avm_writedata,
   output logic                   avm_waitrequest,
   output logic [data_w-1:0]      avm_readdata,
   output logic                   avm_readdatavalid
);

   logic [data_w-1:0] mem [logic [addr_w-1:0]];
   logic [data_w-1:0] rd_word;
   int                rd_cnt;

   function automatic logic [data_w-1:0] fetch_word(input logic [addr_w-1:0] a);
      if (mem.exists(a))
         return mem[a];
      return a ^ 32'hA5A5_A5A5;
   endfunction

   function automatic logic [data_w-1:0] merge_lanes(input logic [data_w-1:0] old_word,
                                                     input logic [data_w-1:0] new_word,
                                                     input logic [num_symbols-1:0] be);
      logic [data_w-1:0] w;
      w = old_word;
      for (int i = 0; i < num_symbols; i++)
         if (be[i])
            w[i*symbol_w +: symbol_w] = new_word[i*symbol_w +: symbol_w];
      return w;
   endfunction

   always @(posedge api_clk or posedge api_reset) begin
      if (api_reset) begin
         avm_waitrequest   <= 1'b0;
         avm_readdata      <= '0;
         avm_readdatavalid <= 1'b0;
         rd_cnt            <= 0;
      end else begin
         // wait-request is high roughly one cycle in three
         avm_waitrequest   <= ($urandom_range(0, 2) == 0);
         avm_readdatavalid <= 1'b0;
         if (avm_write && !avm_waitrequest)
            mem[avm_address] = merge_lanes(fetch_word(avm_address), avm_writedata,
                                           avm_byteenable);
         if (avm_read && !avm_waitrequest) begin
            rd_word <= fetch_word(avm_address);
            rd_cnt  <= $urandom_range(1, 3);
         end else if (rd_cnt == 1) begin
            avm_readdatavalid <= 1'b1;
            avm_readdata      <= rd_word;
            rd_cnt            <= 0;
         end else if (rd_cnt > 1) begin
            rd_cnt <= rd_cnt - 1;
         end
      end
   end

endmodule

`default_nettype wire

/* tb/tb_mm_api_master.sv */
/*
 * Testbench for the command-streaming bus master. Calls are driven on
 * the falling edge, a reference model predicts each return, and an
 * always block checks returns and counts events on the rising edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mm_api_master
   import mm_api_pkg::*;
();

   localparam int cmd_depth    = 4;
   localparam int resp_depth   = 4;
   localparam int num_batches  = 24;
   localparam int settle_tries = 100;
   // a batch stays well under 60 calls, the fixed tests under 400
   localparam int call_budget  = num_batches * 60 + 400;

   logic                     api_clk;
   logic                     api_reset;
   logic                     api_call_valid;
   logic [method_w-1:0]      api_call_method;
   logic [call_data_w-1:0]   api_call_data;
   logic                     api_return_valid;
   logic [method_w-1:0]      api_return_method;
   logic [return_data_w-1:0] api_return_data;
   logic                     api_event_valid;
   logic [event_w-1:0]       api_event_data;
   logic                     avm_read;
   logic                     avm_write;
   logic [addr_w-1:0]        avm_address;
   logic [num_symbols-1:0]   avm_byteenable;
   logic [data_w-1:0]        avm_writedata;
   logic                     avm_waitrequest;
   logic [data_w-1:0]        avm_readdata;
   logic                     avm_readdatavalid;

   // reference model state
   mm_cmd_t           staged_ref;
   logic [data_w-1:0] shadow [logic [addr_w-1:0]];
   mm_resp_t          resp_ref [$];
   int                accepted_pushes = 0;

   // expected returns, oldest first
   logic [method_w-1:0]      exp_method [$];
   logic [return_data_w-1:0] exp_data [$];
   bit                       exp_check [$];
   logic                     call_valid_q = 1'b0;
   int                       issue_events = 0;
   int                       complete_events = 0;
   int                       all_events = 0;

   mm_api_master_top #(.cmd_depth(cmd_depth), .resp_depth(resp_depth)) dut (.*);

   mm_slave_model u_slave (.*);

   initial begin
      api_clk = 1'b0;
      forever #10 api_clk = ~api_clk;
   end

   task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("[ERROR] %0d ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp, act);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_failure(input string what);
      $display("%0d ns: %s", $time, what);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [data_w-1:0] shadow_word(input logic [addr_w-1:0] a);
      if (shadow.exists(a))
         return shadow[a];
      return a ^ 32'hA5A5_A5A5;
   endfunction

   // expected return of one call; applies the call to the model afterwards
   function automatic logic [63:0] ref_call(input logic [7:0] m, input logic [63:0] arg);
      logic [63:0]       r;
      int                n;
      int                in_resp;
      mm_resp_t          t;
      logic [data_w-1:0] w;
      r = '0;
      n = resp_ref.size();
      // in a settled master the response queue fills first
      in_resp = (n > resp_depth) ? resp_depth : n;
      case (m)
         init: begin
            staged_ref = '{write: 1'b0, addr: '0, data: '0, be: '1};
            r = 1;
         end
         set_cmd_data: begin
            staged_ref.data = arg[data_w-1:0];
            r = 1;
         end
         set_cmd_address: begin
            staged_ref.addr = arg[addr_w-1:0];
            r = 1;
         end
         set_cmd_byte_enable: begin
            staged_ref.be = arg[num_symbols-1:0];
            r = 1;
         end
         set_cmd_request:
            if (arg[1:0] == 2'b00 || arg[1:0] == 2'b01) begin
               staged_ref.write = arg[0];
               r = 1;
            end
         push_cmd:
            if (n < cmd_depth + resp_depth) begin
               t.write = staged_ref.write;
               t.addr  = staged_ref.addr;
               t.be    = staged_ref.be;
               w = shadow_word(staged_ref.addr);
               if (staged_ref.write) begin
                  for (int i = 0; i < num_symbols; i++)
                     if (staged_ref.be[i])
                        w[i*symbol_w +: symbol_w] = staged_ref.data[i*symbol_w +: symbol_w];
                  shadow[staged_ref.addr] = w;
                  t.data = staged_ref.data;
               end else begin
                  t.data = w;
               end
               resp_ref.push_back(t);
               accepted_pushes++;
               r = 1;
            end
         pop_resp:
            if (n > 0) begin
               void'(resp_ref.pop_front());
               r = 1;
            end
         all_trans_complete:      r = (n <= resp_depth);
         get_cmd_pend_queue_size: r = n - in_resp;
         get_resp_queue_size:     r = in_resp;
         get_resp_request:        r = (n > 0) ? 64'(resp_ref[0].write) : 64'd0;
         get_resp_data:           r = (n > 0) ? 64'(resp_ref[0].data) : 64'd0;
         get_resp_address:        r = (n > 0) ? 64'(resp_ref[0].addr) : 64'd0;
         get_resp_byte_enable:    r = (n > 0) ? 64'(resp_ref[0].be) : 64'd0;
         default:                 r = '0;
      endcase
      return r;
   endfunction

   task automatic issue_call(input logic [7:0] m, input logic [63:0] arg, input bit check,
                             output logic [63:0] ret);
      logic [63:0] exp;
      exp = check ? ref_call(m, arg) : 64'd0;
      @(negedge api_clk);
      exp_method.push_back(m);
      exp_data.push_back(exp);
      exp_check.push_back(check);
      api_call_valid  = 1'b1;
      api_call_method = m;
      api_call_data   = arg;
      @(negedge api_clk);
      api_call_valid  = 1'b0;
      api_call_method = '0;
      api_call_data   = '0;
      ret = api_return_data;
   endtask

   task automatic checked_call(input logic [7:0] m, input logic [63:0] arg);
      logic [63:0] ret;
      issue_call(m, arg, 1'b1, ret);
   endtask

   // poll until the engine can make no more progress on its own
   task automatic wait_settled();
      logic [63:0] ret;
      int          want;
      int          tries;
      want  = (resp_ref.size() > resp_depth) ? resp_depth : resp_ref.size();
      tries = 0;
      do begin
         issue_call(get_resp_queue_size, 64'd0, 1'b0, ret);
         tries++;
      end while (ret != want && tries < settle_tries);
      assert (ret == want)
         else report_failure("response queue never reached its expected occupancy");
   endtask

   task automatic stage_command(input bit wr, input logic [63:0] addr,
                                input logic [63:0] data, input logic [63:0] be);
      checked_call(set_cmd_request, {63'd0, wr});
      checked_call(set_cmd_address, addr);
      checked_call(set_cmd_data, data);
      checked_call(set_cmd_byte_enable, be);
   endtask

   task automatic check_head_and_pop();
      checked_call(get_resp_request, 64'd0);
      checked_call(get_resp_data, 64'd0);
      checked_call(get_resp_address, 64'd0);
      checked_call(get_resp_byte_enable, 64'd0);
      checked_call(pop_resp, 64'd0);
   endtask

   always @(posedge api_clk) begin
      logic [method_w-1:0]      m;
      logic [return_data_w-1:0] d;
      bit                       c;
      if (!api_reset) begin
         assert (api_return_valid == call_valid_q)
            else report_mismatch("api_return_valid", call_valid_q, api_return_valid);
         assert (api_return_valid || api_return_data == '0)
            else report_mismatch("api_return_data", 64'd0, api_return_data);
         if (api_return_valid) begin
            assert (exp_method.size() > 0)
               else report_failure("a return arrived with no call pending");
            m = exp_method.pop_front();
            d = exp_data.pop_front();
            c = exp_check.pop_front();
            assert (api_return_method == m)
               else report_mismatch("api_return_method", m, api_return_method);
            if (c)
               assert (api_return_data == d)
                  else report_mismatch("api_return_data", d, api_return_data);
         end
         if (api_event_valid) begin
            issue_events    += api_event_data[ev_command_issued];
            complete_events += api_event_data[ev_response_complete];
            all_events      += api_event_data[ev_all_trans_complete];
         end
      end
      call_valid_q = api_call_valid;
   end

   initial begin
      #(longint'(call_budget) * 200 + 20000);
      $display("timeout: the run did not finish within its time budget");
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      int                batch;
      int                k;
      int                n;
      logic [addr_w-1:0] a;
      void'($urandom(66));
      staged_ref      = '{write: 1'b0, addr: '0, data: '0, be: '1};
      api_reset       = 1'b1;
      api_call_valid  = 1'b0;
      api_call_method = '0;
      api_call_data   = '0;
      repeat (10) @(posedge api_clk);
      @(negedge api_clk);
      api_reset = 1'b0;

      // setters, bad request codes and undefined methods
      checked_call(init, 64'd0);
      checked_call(set_cmd_request, 64'd2);
      checked_call(set_cmd_request, 64'd3);
      checked_call(8'd1, 64'h1234);
      checked_call(8'd4, 64'd0);
      checked_call(8'd12, 64'd0);
      checked_call(8'd255, 64'hffff);
      checked_call(all_trans_complete, 64'd0);
      checked_call(get_resp_queue_size, 64'd0);

      // random reads and writes in small batches
      for (batch = 0; batch < num_batches; batch++) begin
         n = $urandom_range(1, 3);
         for (k = 0; k < n; k++) begin
            a = 32'h1000 + 4 * $urandom_range(0, 15);
            stage_command($urandom_range(0, 1), {$urandom, a}, {$urandom, $urandom},
                          $urandom_range(0, 15));
            checked_call(push_cmd, 64'd0);
         end
         wait_settled();
         checked_call(all_trans_complete, 64'd0);
         checked_call(get_cmd_pend_queue_size, 64'd0);
         for (k = 0; k < n; k++)
            check_head_and_pop();
      end

      // fill the response queue, then the fifth push is refused
      checked_call(init, 64'd0);
      for (k = 0; k < resp_depth; k++) begin
         stage_command(1'b1, 32'h2000 + 4 * k, $urandom, 64'hf);
         checked_call(push_cmd, 64'd0);
      end
      wait_settled();
      stage_command(1'b0, 32'h2004, 64'd0, 64'hf);
      for (k = 0; k < 5; k++)
         checked_call(push_cmd, 64'd0);
      checked_call(get_cmd_pend_queue_size, 64'd0);
      checked_call(get_resp_queue_size, 64'd0);
      checked_call(all_trans_complete, 64'd0);
      while (resp_ref.size() > 0) begin
         check_head_and_pop();
         wait_settled();
         checked_call(get_cmd_pend_queue_size, 64'd0);
         checked_call(get_resp_queue_size, 64'd0);
      end

      // empty response queue
      checked_call(pop_resp, 64'd0);
      checked_call(get_resp_request, 64'd0);
      checked_call(get_resp_data, 64'd0);
      checked_call(get_resp_address, 64'd0);
      checked_call(get_resp_byte_enable, 64'd0);
      checked_call(all_trans_complete, 64'd0);

      repeat (5) @(negedge api_clk);
      assert (exp_method.size() == 0)
         else report_failure("a call never got its return");
      assert (issue_events == accepted_pushes)
         else report_mismatch("command issued events", accepted_pushes, issue_events);
      assert (complete_events == accepted_pushes)
         else report_mismatch("response complete events", accepted_pushes, complete_events);
      assert (all_events > 0)
         else report_failure("no all-complete event was seen");
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
verilog/mm_api_pkg.sv
verilog/mm_api_fifo.sv
verilog/mm_api_decoder.sv
verilog/mm_bus_engine.sv
verilog/mm_event_gen.sv
verilog/mm_api_master_top.sv
tb/mm_slave_model.sv
tb/tb_mm_api_master.sv
